// ==== Bender.yml ====
package:
  name: lc4_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lc4_pkg.sv
      - rtl/lc4_stage_if.sv
      - rtl/lc4_fetch.sv
      - rtl/lc4_decode.sv
      - rtl/lc4_execute.sv
      - rtl/lc4_memory_writeback.sv
      - rtl/lc4_core.sv
  - target: test
    include_dirs:
      - rtl
      - test
    files:
      - test/tb_lc4_core.sv

// ==== rtl/lc4_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module lc4_core (
    input  logic           gwe,
    input  logic           i_rst_n,
    output lc4_pkg::word_t o_imem_addr,
    input  lc4_pkg::word_t i_imem_data,
    output lc4_pkg::word_t o_dmem_addr,
    output logic           o_dmem_we,
    output lc4_pkg::word_t o_dmem_wdata,
    input  lc4_pkg::word_t i_dmem_rdata
);

    lc4_pkg::word_t    f_pc;
    lc4_pkg::word_t    f_insn;
    logic              f_valid;
    logic              stall;
    logic              redirect;
    lc4_pkg::word_t    target;
    logic              wb_we;
    lc4_pkg::reg_sel_t wb_rd;
    lc4_pkg::word_t    wb_data;

    lc4_stage_if d2x ();
    lc4_stage_if x2m ();

    lc4_fetch u_fetch (
        .gwe         (gwe),
        .i_rst_n     (i_rst_n),
        .i_stall     (stall),
        .i_redirect  (redirect),
        .i_target    (target),
        .o_imem_addr (o_imem_addr),
        .i_imem_data (i_imem_data),
        .o_pc        (f_pc),
        .o_insn      (f_insn),
        .o_valid     (f_valid)
    );

    // the load-use check looks at the slot decode hands to execute
    lc4_decode u_decode (
        .gwe        (gwe),
        .i_rst_n    (i_rst_n),
        .i_pc       (f_pc),
        .i_insn     (f_insn),
        .i_valid    (f_valid),
        .i_redirect (redirect),
        .o_stall    (stall),
        .i_wb_we    (wb_we),
        .i_wb_rd    (wb_rd),
        .i_wb_data  (wb_data),
        .x_in       (d2x.consumer),
        .d2x        (d2x.producer)
    );

    lc4_execute u_execute (
        .gwe        (gwe),
        .i_rst_n    (i_rst_n),
        .d2x        (d2x.consumer),
        .x2m        (x2m.producer),
        .i_wb_we    (wb_we),
        .i_wb_rd    (wb_rd),
        .i_wb_data  (wb_data),
        .o_redirect (redirect),
        .o_target   (target)
    );

    lc4_memory_writeback u_mem_wb (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .x2m          (x2m.consumer),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_wdata (o_dmem_wdata),
        .i_dmem_rdata (i_dmem_rdata),
        .o_wb_we      (wb_we),
        .o_wb_rd      (wb_rd),
        .o_wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// ==== rtl/lc4_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lc4_params.svh"

module lc4_decode (
    input  logic              gwe,
    input  logic              i_rst_n,
    input  lc4_pkg::word_t    i_pc,
    input  lc4_pkg::word_t    i_insn,
    input  logic              i_valid,
    input  logic              i_redirect,
    output logic              o_stall,
    input  logic              i_wb_we,
    input  lc4_pkg::reg_sel_t i_wb_rd,
    input  lc4_pkg::word_t    i_wb_data,
    // the instruction now sitting in execute
    lc4_stage_if.consumer     x_in,
    lc4_stage_if.producer     d2x
);

    lc4_pkg::ctrl_t ctrl;
    lc4_pkg::word_t regs [0:(1 << `LC4_REG_SEL_W)-1];
    lc4_pkg::word_t rs_rd;
    lc4_pkg::word_t rt_rd;
    logic           is_logic;
    logic           use_rs;
    logic           use_rt;

    assign is_logic = (i_insn[15:12] == `LC4_OP_LOGIC);

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = lc4_pkg::ALU_PASS;
        ctrl.rs     = i_insn[8:6];
        ctrl.rt     = i_insn[2:0];
        ctrl.rd     = i_insn[11:9];
        case (i_insn[15:12])
            `LC4_OP_BR: begin
                ctrl.is_branch = 1'b1;
            end
            `LC4_OP_ARITH, `LC4_OP_LOGIC: begin
                casez (i_insn[5:3])
                    3'b1??: begin
                        ctrl.alu_op = is_logic ? lc4_pkg::ALU_ANDI : lc4_pkg::ALU_ADDI;
                    end
                    3'b000: begin
                        ctrl.alu_op = is_logic ? lc4_pkg::ALU_AND : lc4_pkg::ALU_ADD;
                        ctrl.rt_re  = 1'b1;
                    end
                    3'b010: begin
                        ctrl.alu_op = is_logic ? lc4_pkg::ALU_OR : lc4_pkg::ALU_SUB;
                        ctrl.rt_re  = 1'b1;
                    end
                    // mul, div, not, xor fall out as NOP
                    default: ctrl.alu_op = lc4_pkg::ALU_PASS;
                endcase
                ctrl.rs_re  = (ctrl.alu_op != lc4_pkg::ALU_PASS);
                ctrl.rf_we  = ctrl.rs_re;
                ctrl.nzp_we = ctrl.rs_re;
            end
            `LC4_OP_LDR: begin
                ctrl.rs_re   = 1'b1;
                ctrl.rf_we   = 1'b1;
                ctrl.nzp_we  = 1'b1;
                ctrl.is_load = 1'b1;
                ctrl.alu_op  = lc4_pkg::ALU_ADDR;
            end
            `LC4_OP_STR: begin
                // store data register lives in the rd field
                ctrl.rt       = i_insn[11:9];
                ctrl.rs_re    = 1'b1;
                ctrl.rt_re    = 1'b1;
                ctrl.is_store = 1'b1;
                ctrl.alu_op   = lc4_pkg::ALU_ADDR;
            end
            `LC4_OP_CONST: begin
                ctrl.rf_we  = 1'b1;
                ctrl.nzp_we = 1'b1;
                ctrl.alu_op = lc4_pkg::ALU_CONST;
            end
            default: ctrl.alu_op = lc4_pkg::ALU_PASS;
        endcase
    end

    always_ff @(posedge gwe) begin
        if (i_wb_we) begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    // same-cycle writeback shows through to the read ports
    assign rs_rd = (i_wb_we && i_wb_rd == ctrl.rs) ? i_wb_data : regs[ctrl.rs];
    assign rt_rd = (i_wb_we && i_wb_rd == ctrl.rt) ? i_wb_data : regs[ctrl.rt];

    // stall when a load in execute feeds this slot
    // store data needs no stall since the WM path delivers it
    // a branch also waits for the load's NZP
    assign use_rs  = ctrl.rs_re && (ctrl.rs == x_in.ctrl.rd);
    assign use_rt  = ctrl.rt_re && !ctrl.is_store && (ctrl.rt == x_in.ctrl.rd);
    assign o_stall = i_valid && x_in.valid && x_in.ctrl.is_load &&
                     (use_rs || use_rt || ctrl.is_branch);

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            d2x.valid <= 1'b0;
        end else begin
            d2x.valid <= i_valid && !i_redirect && !o_stall;
        end
    end

    always_ff @(posedge gwe) begin
        d2x.pc     <= i_pc;
        d2x.insn   <= i_insn;
        d2x.ctrl   <= ctrl;
        d2x.rs_val <= rs_rd;
        d2x.rt_val <= rt_rd;
    end

endmodule

`default_nettype wire

// ==== rtl/lc4_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lc4_params.svh"

module lc4_execute (
    input  logic              gwe,
    input  logic              i_rst_n,
    lc4_stage_if.consumer     d2x,
    lc4_stage_if.producer     x2m,
    input  logic              i_wb_we,
    input  lc4_pkg::reg_sel_t i_wb_rd,
    input  lc4_pkg::word_t    i_wb_data,
    output logic              o_redirect,
    output lc4_pkg::word_t    o_target
);

    lc4_pkg::word_t rs_op;
    lc4_pkg::word_t rt_op;
    lc4_pkg::word_t alu_res;
    lc4_pkg::word_t imm5;
    lc4_pkg::word_t imm6;
    lc4_pkg::word_t imm9;
    lc4_pkg::nzp_t  nzp_q;
    lc4_pkg::nzp_t  nzp_cur;
    logic           ld_in_w_q;
    logic           mx_ok;

    function automatic lc4_pkg::nzp_t nzp_of(input lc4_pkg::word_t value);
        if (value[`LC4_WORD_W-1]) begin
            return 3'b100;
        end else if (value == '0) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    // memory-stage result first, then writeback, then the register read
    function automatic lc4_pkg::word_t bypass(input lc4_pkg::reg_sel_t sel,
                                              input lc4_pkg::word_t   dval);
        if (mx_ok && x2m.ctrl.rd == sel) begin
            return x2m.rs_val;
        end else if (i_wb_we && i_wb_rd == sel) begin
            return i_wb_data;
        end
        return dval;
    endfunction

    // a load in memory has no data yet
    // the load-use stall keeps its consumers out of execute
    assign mx_ok = x2m.valid && x2m.ctrl.rf_we && !x2m.ctrl.is_load;

    always_comb begin
        rs_op = bypass(d2x.ctrl.rs, d2x.rs_val);
        rt_op = bypass(d2x.ctrl.rt, d2x.rt_val);
    end

    assign imm5 = {{(`LC4_WORD_W-5){d2x.insn[4]}}, d2x.insn[4:0]};
    assign imm6 = {{(`LC4_WORD_W-6){d2x.insn[5]}}, d2x.insn[5:0]};
    assign imm9 = {{(`LC4_WORD_W-9){d2x.insn[8]}}, d2x.insn[8:0]};

    always_comb begin
        case (d2x.ctrl.alu_op)
            lc4_pkg::ALU_ADD:   alu_res = rs_op + rt_op;
            lc4_pkg::ALU_SUB:   alu_res = rs_op - rt_op;
            lc4_pkg::ALU_AND:   alu_res = rs_op & rt_op;
            lc4_pkg::ALU_OR:    alu_res = rs_op | rt_op;
            lc4_pkg::ALU_ADDI:  alu_res = rs_op + imm5;
            lc4_pkg::ALU_ANDI:  alu_res = rs_op & imm5;
            lc4_pkg::ALU_CONST: alu_res = imm9;
            lc4_pkg::ALU_ADDR:  alu_res = rs_op + imm6;
            default:            alu_res = rs_op;
        endcase
    end

    // a load sitting in writeback whose NZP nobody younger has overwritten
    assign nzp_cur    = ld_in_w_q ? nzp_of(i_wb_data) : nzp_q;
    assign o_redirect = d2x.valid && d2x.ctrl.is_branch && |(d2x.insn[11:9] & nzp_cur);
    assign o_target   = d2x.pc + 1'b1 + imm9;

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            nzp_q     <= '0;
            ld_in_w_q <= 1'b0;
            x2m.valid <= 1'b0;
        end else begin
            if (d2x.valid && d2x.ctrl.nzp_we && !d2x.ctrl.is_load) begin
                nzp_q <= nzp_of(alu_res);
            end else if (ld_in_w_q) begin
                nzp_q <= nzp_of(i_wb_data);
            end
            ld_in_w_q <= x2m.valid && x2m.ctrl.is_load && !(d2x.valid && d2x.ctrl.nzp_we);
            x2m.valid <= d2x.valid;
        end
    end

    always_ff @(posedge gwe) begin
        x2m.pc     <= d2x.pc;
        x2m.insn   <= d2x.insn;
        x2m.ctrl   <= d2x.ctrl;
        x2m.rs_val <= alu_res;
        x2m.rt_val <= rt_op;
    end

endmodule

`default_nettype wire

// ==== rtl/lc4_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lc4_params.svh"

module lc4_fetch (
    input  logic           gwe,
    input  logic           i_rst_n,
    input  logic           i_stall,
    input  logic           i_redirect,
    input  lc4_pkg::word_t i_target,
    output lc4_pkg::word_t o_imem_addr,
    input  lc4_pkg::word_t i_imem_data,
    output lc4_pkg::word_t o_pc,
    output lc4_pkg::word_t o_insn,
    output logic           o_valid
);

    lc4_pkg::word_t pc_q;

    assign o_imem_addr = pc_q;

    // redirect wins over a stall, the slot behind a taken branch is dead anyway
    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q    <= `LC4_RESET_PC;
            o_valid <= 1'b0;
        end else if (i_redirect) begin
            pc_q    <= i_target;
            o_valid <= 1'b0;
        end else if (!i_stall) begin
            pc_q    <= pc_q + 1'b1;
            o_valid <= 1'b1;
        end
    end

    // fetch-to-decode payload, held while decode stalls
    always_ff @(posedge gwe) begin
        if (!i_stall) begin
            o_pc   <= pc_q;
            o_insn <= i_imem_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lc4_memory_writeback.sv ====
`timescale 1ns/1ns
`default_nettype none

module lc4_memory_writeback (
    input  logic              gwe,
    input  logic              i_rst_n,
    lc4_stage_if.consumer     x2m,
    output lc4_pkg::word_t    o_dmem_addr,
    output logic              o_dmem_we,
    output lc4_pkg::word_t    o_dmem_wdata,
    input  lc4_pkg::word_t    i_dmem_rdata,
    output logic              o_wb_we,
    output lc4_pkg::reg_sel_t o_wb_rd,
    output lc4_pkg::word_t    o_wb_data
);

    lc4_stage_if m2w ();

    // address comes straight from the ALU result
    assign o_dmem_addr = x2m.rs_val;
    assign o_dmem_we   = x2m.valid && x2m.ctrl.is_store;

    // load right before a store, its data only exists in writeback now
    assign o_dmem_wdata = (o_wb_we && o_wb_rd == x2m.ctrl.rt) ? o_wb_data : x2m.rt_val;

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            m2w.valid <= 1'b0;
        end else begin
            m2w.valid <= x2m.valid;
        end
    end

    always_ff @(posedge gwe) begin
        m2w.pc     <= x2m.pc;
        m2w.insn   <= x2m.insn;
        m2w.ctrl   <= x2m.ctrl;
        m2w.rs_val <= x2m.rs_val;
        m2w.rt_val <= i_dmem_rdata;
    end

    // writeback half
    assign o_wb_we   = m2w.valid && m2w.ctrl.rf_we;
    assign o_wb_rd   = m2w.ctrl.rd;
    assign o_wb_data = m2w.ctrl.is_load ? m2w.rt_val : m2w.rs_val;

endmodule

`default_nettype wire

// ==== rtl/lc4_params.svh ====
`ifndef LC4_PARAMS_SVH
`define LC4_PARAMS_SVH

// data words, addresses and instructions share one width
`define LC4_WORD_W 16

// eight architectural registers
`define LC4_REG_SEL_W 3

// first fetch address out of reset
`define LC4_RESET_PC 16'h8200

// major opcodes in insn[15:12]
`define LC4_OP_BR 4'b0000
`define LC4_OP_ARITH 4'b0001
`define LC4_OP_LOGIC 4'b0101
`define LC4_OP_LDR 4'b0110
`define LC4_OP_STR 4'b0111
`define LC4_OP_CONST 4'b1001

`endif

// ==== rtl/lc4_pkg.sv ====
`default_nettype none

`include "lc4_params.svh"

package lc4_pkg;

    typedef logic [`LC4_WORD_W-1:0] word_t;

    typedef logic [`LC4_REG_SEL_W-1:0] reg_sel_t;

    // bit 2 negative, bit 1 zero, bit 0 positive
    typedef logic [2:0] nzp_t;

    // pass-through must stay at zero, it is the NOP encoding
    typedef enum logic [3:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_ADDI,
        ALU_ANDI,
        ALU_CONST,
        ALU_ADDR
    } alu_op_t;

    typedef struct packed {
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rf_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        alu_op_t  alu_op;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== rtl/lc4_stage_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// one instruction slot between two pipeline stages
interface lc4_stage_if;

    logic           valid;
    lc4_pkg::word_t pc;
    lc4_pkg::word_t insn;
    lc4_pkg::ctrl_t ctrl;

    // operand slots, their meaning shifts along the pipe:
    // decode->execute   rs_val/rt_val are the register reads
    // execute->memory   rs_val is the ALU result, rt_val the store data
    // memory->writeback rs_val is the ALU result, rt_val the load data
    lc4_pkg::word_t rs_val;
    lc4_pkg::word_t rt_val;

    modport producer (
        output valid,
        output pc,
        output insn,
        output ctrl,
        output rs_val,
        output rt_val
    );

    modport consumer (
        input valid,
        input pc,
        input insn,
        input ctrl,
        input rs_val,
        input rt_val
    );

endinterface

`default_nettype wire

// ==== sources.f ====
+incdir+rtl
+incdir+test
rtl/lc4_pkg.sv
rtl/lc4_stage_if.sv
rtl/lc4_fetch.sv
rtl/lc4_decode.sv
rtl/lc4_execute.sv
rtl/lc4_memory_writeback.sv
rtl/lc4_core.sv
test/tb_lc4_core.sv

// ==== test/tb_lc4_programs.svh ====
`ifndef TB_LC4_PROGRAMS_SVH
`define TB_LC4_PROGRAMS_SVH

localparam int NUM_TESTS  = 6;
localparam int MAX_WORDS  = 12;
localparam int MAX_STORES = 3;

string       test_name [NUM_TESTS];
logic [15:0] prog      [NUM_TESTS][MAX_WORDS];
int          prog_len  [NUM_TESTS];
int          store_cnt [NUM_TESTS];
logic [15:0] exp_addr  [NUM_TESTS][MAX_STORES];
logic [15:0] exp_data  [NUM_TESTS][MAX_STORES];

function automatic logic [15:0] enc_const(input int rd, input int imm);
    return {`LC4_OP_CONST, rd[2:0], imm[8:0]};
endfunction

// register-register form, sub selects add/and (000) or sub/or (010)
function automatic logic [15:0] enc_reg(input logic [3:0] op, input int rd, input int rs,
                                        input logic [2:0] sub, input int rt);
    return {op, rd[2:0], rs[2:0], sub, rt[2:0]};
endfunction

function automatic logic [15:0] enc_imm(input logic [3:0] op, input int rd, input int rs,
                                        input int imm);
    return {op, rd[2:0], rs[2:0], 1'b1, imm[4:0]};
endfunction

// LDR and STR share the layout, for STR the first register is the data
function automatic logic [15:0] enc_mem(input logic [3:0] op, input int r, input int base,
                                        input int off);
    return {op, r[2:0], base[2:0], off[5:0]};
endfunction

function automatic logic [15:0] enc_br(input logic [2:0] nzp, input int off);
    return {`LC4_OP_BR, nzp, off[8:0]};
endfunction

task automatic put(input int t, input logic [15:0] word);
    prog[t][prog_len[t]] = word;
    prog_len[t]++;
endtask

task automatic expect_store(input int t, input logic [15:0] addr, input logic [15:0] data);
    exp_addr[t][store_cnt[t]] = addr;
    exp_data[t][store_cnt[t]] = data;
    store_cnt[t]++;
endtask

// data memory reads back 16'h4000 + address where nothing was stored
task automatic fill_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
        prog_len[t]  = 0;
        store_cnt[t] = 0;
    end

    test_name[0] = "alu_const";
    put(0, enc_const(1, 5));
    put(0, enc_const(2, -3));
    put(0, enc_reg(`LC4_OP_ARITH, 3, 1, 3'b000, 2));
    put(0, enc_reg(`LC4_OP_ARITH, 4, 3, 3'b010, 1));
    put(0, enc_reg(`LC4_OP_LOGIC, 5, 4, 3'b000, 1));
    put(0, enc_reg(`LC4_OP_LOGIC, 6, 5, 3'b010, 2));
    put(0, enc_imm(`LC4_OP_ARITH, 6, 6, -1));
    put(0, enc_imm(`LC4_OP_LOGIC, 7, 1, 6));
    put(0, enc_const(0, 16));
    put(0, enc_mem(`LC4_OP_STR, 6, 0, 0));
    put(0, enc_mem(`LC4_OP_STR, 7, 0, 1));
    put(0, enc_mem(`LC4_OP_STR, 3, 0, 2));
    expect_store(0, 16'h0010, 16'hfffc);
    expect_store(0, 16'h0011, 16'h0004);
    expect_store(0, 16'h0012, 16'h0002);

    test_name[1] = "load_use";
    put(1, enc_const(0, 32));
    put(1, enc_const(1, 7));
    put(1, enc_mem(`LC4_OP_LDR, 2, 0, 3));
    put(1, enc_reg(`LC4_OP_ARITH, 3, 2, 3'b000, 1));
    put(1, enc_mem(`LC4_OP_STR, 3, 0, 0));
    put(1, enc_mem(`LC4_OP_LDR, 4, 0, -1));
    put(1, enc_imm(`LC4_OP_ARITH, 5, 4, 1));
    put(1, enc_mem(`LC4_OP_STR, 5, 0, 1));
    expect_store(1, 16'h0020, 16'h402a);
    expect_store(1, 16'h0021, 16'h4020);

    test_name[2] = "store_bypass";
    put(2, enc_const(0, 48));
    put(2, enc_const(1, 9));
    put(2, enc_mem(`LC4_OP_STR, 1, 0, 0));
    put(2, enc_mem(`LC4_OP_LDR, 2, 0, 5));
    put(2, enc_mem(`LC4_OP_STR, 2, 0, 1));
    put(2, enc_imm(`LC4_OP_ARITH, 1, 1, 2));
    put(2, enc_mem(`LC4_OP_STR, 1, 0, 2));
    expect_store(2, 16'h0030, 16'h0009);
    expect_store(2, 16'h0031, 16'h4035);
    expect_store(2, 16'h0032, 16'h000b);

    test_name[3] = "branch_taken";
    put(3, enc_const(0, 64));
    put(3, enc_const(1, 1));
    put(3, enc_const(2, 0));
    put(3, enc_br(3'b010, 2));
    put(3, enc_mem(`LC4_OP_STR, 1, 0, 0));
    put(3, enc_mem(`LC4_OP_STR, 1, 0, 1));
    put(3, enc_mem(`LC4_OP_STR, 1, 0, 2));
    put(3, enc_imm(`LC4_OP_ARITH, 3, 1, -2));
    put(3, enc_br(3'b100, 1));
    put(3, enc_mem(`LC4_OP_STR, 1, 0, 3));
    put(3, enc_mem(`LC4_OP_STR, 3, 0, 4));
    expect_store(3, 16'h0042, 16'h0001);
    expect_store(3, 16'h0044, 16'hffff);

    test_name[4] = "branch_not_taken";
    put(4, enc_const(0, 80));
    put(4, enc_const(1, 3));
    put(4, enc_br(3'b110, 1));
    put(4, enc_mem(`LC4_OP_STR, 1, 0, 0));
    put(4, enc_mem(`LC4_OP_LDR, 2, 0, 0));
    put(4, enc_br(3'b110, 1));
    put(4, enc_mem(`LC4_OP_STR, 2, 0, 1));
    put(4, enc_const(3, -1));
    put(4, enc_br(3'b011, 1));
    put(4, enc_mem(`LC4_OP_STR, 3, 0, 2));
    expect_store(4, 16'h0050, 16'h0003);
    expect_store(4, 16'h0051, 16'h0003);
    expect_store(4, 16'h0052, 16'hffff);

    // mul, shift, trap and xor encodings
    test_name[5] = "nop_encoding";
    put(5, enc_const(0, 96));
    put(5, enc_const(1, 12));
    put(5, 16'h1249);
    put(5, 16'ha241);
    put(5, 16'hf0ff);
    put(5, enc_mem(`LC4_OP_STR, 1, 0, 0));
    put(5, 16'h5259);
    put(5, enc_mem(`LC4_OP_STR, 1, 0, 1));
    expect_store(5, 16'h0060, 16'h000c);
    expect_store(5, 16'h0061, 16'h000c);
endtask

`endif

// ==== test/tb_lc4_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lc4_params.svh"

module tb_lc4_core;

    localparam int RESET_CYCLES = 16;

    logic        gwe;
    logic        i_rst_n;
    logic [15:0] o_imem_addr;
    logic [15:0] i_imem_data;
    logic [15:0] o_dmem_addr;
    logic        o_dmem_we;
    logic [15:0] o_dmem_wdata;
    logic [15:0] i_dmem_rdata;

    logic [15:0] imem [0:255];
    logic [15:0] dmem [0:255];
    logic [15:0] imem_idx;
    logic [15:0] st_addr [$];
    logic [15:0] st_data [$];
    int          cycles;
    int          limit;

    `include "tb_lc4_programs.svh"

    lc4_core u_dut (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .o_imem_addr  (o_imem_addr),
        .i_imem_data  (i_imem_data),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_wdata (o_dmem_wdata),
        .i_dmem_rdata (i_dmem_rdata)
    );

    // both memories answer in the same cycle
    assign imem_idx     = o_imem_addr - `LC4_RESET_PC;
    assign i_imem_data  = (imem_idx < 16'd256) ? imem[imem_idx[7:0]] : 16'h0000;
    assign i_dmem_rdata = dmem[o_dmem_addr[7:0]];

    initial begin
        gwe = 1'b0;
        forever #50 gwe = ~gwe;
    end

    // stores are sampled mid-cycle where the memory-stage outputs are settled
    always @(negedge gwe) begin
        if (o_dmem_we === 1'b1) begin
            st_addr.push_back(o_dmem_addr);
            st_data.push_back(o_dmem_wdata);
            dmem[o_dmem_addr[7:0]] = o_dmem_wdata;
        end
    end

    always @(posedge gwe) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("=== FAIL ===");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check_value(input string label, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %h actual %h", label, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic load_memories(input int t);
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog_len[t]) ? prog[t][i] : 16'h0000;
            dmem[i] = 16'h4000 + i[15:0];
        end
        st_addr.delete();
        st_data.delete();
    endtask

    task automatic run_test(input int t);
        logic [15:0] end_addr;
        end_addr = `LC4_RESET_PC + prog_len[t][15:0] + 16'd6;
        @(posedge gwe);
        i_rst_n <= 1'b0;
        load_memories(t);
        repeat (RESET_CYCLES - 1) @(posedge gwe);
        // fetch starts at the reset vector and no store is pending
        @(negedge gwe);
        check_value($sformatf("%s reset pc", test_name[t]), `LC4_RESET_PC, o_imem_addr);
        check_value($sformatf("%s reset dmem we", test_name[t]), 16'h0000,
                    {15'd0, o_dmem_we});
        @(posedge gwe);
        i_rst_n <= 1'b1;
        // the last instruction has left the memory stage once fetch is this far ahead
        do begin
            @(negedge gwe);
        end while (o_imem_addr < end_addr);
        if (st_addr.size() != store_cnt[t]) begin
            $display("test %s wrote %0d stores to data memory but %0d were expected",
                     test_name[t], st_addr.size(), store_cnt[t]);
            $display("=== FAIL ===");
            $fatal(1, "store count differs");
        end
        for (int s = 0; s < store_cnt[t]; s++) begin
            check_value($sformatf("%s store %0d addr", test_name[t], s),
                        exp_addr[t][s], st_addr[s]);
            check_value($sformatf("%s store %0d data", test_name[t], s),
                        exp_data[t][s], st_data[s]);
        end
    endtask

    initial begin
        i_rst_n = 1'b0;
        cycles  = 0;
        limit   = 0;
        fill_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += prog_len[t] + 24 + RESET_CYCLES;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
